//--- wb_arb_sys.f
+incdir+.
wb_bus_pkg.sv
wb_map_pkg.sv
wb_bus_if.sv
wbm_arbiter.sv
wb_addr_decoder.sv
wb_reg_bank.sv
wb_sram.sv
wb_arb_sys.sv
wb_arb_sys_assertions.sv
tb_wb_arb_sys.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_wb_arb_sys -f wb_arb_sys.f -o sim_wb_arb_sys > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_wb_arb_sys > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q "TB PASSED" sim.log; then
  echo "Simulation did not complete"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- tb_wb_arb_sys.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_settings.svh"

module tb_wb_arb_sys
  import wb_bus_pkg::*;
();

  localparam int N       = `WB_NUM_MASTERS;
  localparam int TIMEOUT = 40;                 // Cycles allowed per wait
  localparam wb_adr_t REG_BASE  = `WB_REG_BASE;
  localparam wb_adr_t SRAM_BASE = `WB_SRAM_BASE;

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  logic [N-1:0]          wbm_cyc_i;
  logic [N-1:0]          wbm_stb_i;
  logic [N-1:0]          wbm_we_i;
  logic [N-1:0]          wbm_mask_i;
  logic [N*`WB_ADR_W-1:0] wbm_adr_i;
  logic [N*`WB_DAT_W-1:0] wbm_dat_i;
  wb_dat_t               wbm_dat_o;
  logic [N-1:0]          wbm_ack_o;
  logic [N-1:0]          wbm_err_o;
  wbm_id_t               wbm_id_o;

  logic [31:0] lfsr_q;
  int          last_lat;                       // Edges without a response, last cycle
  int          resp_order[$];                  // Master indices in response order
  int          wr_count_exp;
  bit          fail_shown;
  bit          run_done;

  wb_arb_sys uut (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_we_i   (wbm_we_i),
    .wbm_adr_i  (wbm_adr_i),
    .wbm_dat_i  (wbm_dat_i),
    .wbm_dat_o  (wbm_dat_o),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_err_o  (wbm_err_o),
    .wbm_mask_i (wbm_mask_i),
    .wbm_id_o   (wbm_id_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [15:0] rand_bits(input int nbits);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic report_fail(input string msg);
    fail_shown = 1'b1;
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      report_fail($sformatf("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                            $time, name, got, exp));
  endtask

  // One classic cycle; request held until this master sees ack or err
  task automatic bus_cycle(input int idx, input logic we, input wb_adr_t adr,
                           input wb_dat_t dat, output wb_dat_t rdata, output logic got_err);
    int   waited;
    logic seen;
    @(posedge wb_clk_i);
    wbm_cyc_i[idx] <= 1'b1;
    wbm_stb_i[idx] <= 1'b1;
    wbm_we_i[idx]  <= we;
    wbm_adr_i[idx*`WB_ADR_W +: `WB_ADR_W] <= adr;
    wbm_dat_i[idx*`WB_DAT_W +: `WB_DAT_W] <= dat;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < TIMEOUT) begin
      @(posedge wb_clk_i);
      if (wbm_ack_o[idx] || wbm_err_o[idx]) begin
        seen = 1'b1;
      end else begin
        waited++;
      end
    end
    if (!seen) begin
      report_fail($sformatf("Master %0d got neither ack nor err for address 0x%0h in time",
                            idx, adr));
    end
    assert (!(wbm_ack_o[idx] && wbm_err_o[idx])) else
      report_fail($sformatf("Master %0d saw ack and err in the same cycle", idx));
    check_val("wbm_id_o", 32'(wbm_id_o), 32'(idx));
    check_val("wbm_ack_o|wbm_err_o of other masters",
              32'((wbm_ack_o | wbm_err_o) & ~(N'(1) << idx)), 32'd0);
    rdata    = wbm_dat_o;
    got_err  = wbm_err_o[idx];
    last_lat = waited;
    resp_order.push_back(idx);
    wbm_cyc_i[idx] <= 1'b0;                    // Dropped at the response edge
    wbm_stb_i[idx] <= 1'b0;
  endtask

  task automatic master_write(input int idx, input wb_adr_t adr, input wb_dat_t dat,
                              input logic exp_err);
    wb_dat_t rdata;
    logic    got_err;
    bus_cycle(idx, 1'b1, adr, dat, rdata, got_err);
    check_val($sformatf("wbm_err_o[%0d]", idx), 32'(got_err), 32'(exp_err));
  endtask

  task automatic master_read(input int idx, input wb_adr_t adr, input wb_dat_t expected,
                             input logic exp_err);
    wb_dat_t rdata;
    logic    got_err;
    bus_cycle(idx, 1'b0, adr, '0, rdata, got_err);
    check_val($sformatf("wbm_err_o[%0d]", idx), 32'(got_err), 32'(exp_err));
    if (!exp_err) begin
      check_val($sformatf("wbm_dat_o @0x%0h", adr), 32'(rdata), 32'(expected));
    end
  endtask

  task automatic test_reset_state();
    check_val("wbm_ack_o", 32'(wbm_ack_o), 32'd0);
    check_val("wbm_err_o", 32'(wbm_err_o), 32'd0);
    check_val("wbm_id_o", 32'(wbm_id_o), 32'd0);
    for (int i = 0; i < 7; i++) begin
      master_read(0, REG_BASE + wb_adr_t'(i), '0, 1'b0);
    end
    master_read(0, REG_BASE + 16'd7, `WB_ARB_VERSION, 1'b0);
  endtask

  task automatic test_reg_bank();
    wb_dat_t vals[6];
    for (int i = 0; i < 6; i++) begin
      vals[i] = rand_bits(16);
      master_write(0, REG_BASE + wb_adr_t'(i), vals[i], 1'b0);
      wr_count_exp++;
      if (i == 0) begin
        check_val("register ack latency", 32'(last_lat), 32'd3);
      end
    end
    for (int i = 0; i < 6; i++) begin
      master_read(0, REG_BASE + wb_adr_t'(i), vals[i], 1'b0);
    end
    master_read(0, REG_BASE + 16'd6, wb_dat_t'(wr_count_exp), 1'b0);
    master_write(0, REG_BASE + 16'd7, 16'hffff, 1'b1); // Version is read-only
    master_read(0, REG_BASE + 16'd7, `WB_ARB_VERSION, 1'b0);
    master_read(0, REG_BASE + 16'd6, wb_dat_t'(wr_count_exp), 1'b0);
  endtask

  task automatic test_sram();
    wb_adr_t a;
    wb_dat_t d;
    for (int i = 0; i < 16; i++) begin
      a = SRAM_BASE + wb_adr_t'(rand_bits($clog2(`WB_SRAM_WORDS)));
      d = rand_bits(16);
      master_write(1, a, d, 1'b0);
      if (i == 0) begin
        check_val("SRAM ack latency", 32'(last_lat), 32'd4);
      end
      master_read(1, a, d, 1'b0);
    end
  endtask

  task automatic test_priority();
    wb_dat_t d[N];
    for (int i = 0; i < N; i++) begin
      d[i] = rand_bits(16);
    end
    resp_order.delete();
    fork
      master_write(0, SRAM_BASE + 16'h00a0, d[0], 1'b0);
      master_write(2, SRAM_BASE + 16'h00a2, d[2], 1'b0);
      master_write(3, SRAM_BASE + 16'h00a3, d[3], 1'b0);
    join
    check_val("response count", 32'(resp_order.size()), 32'd3);
    check_val("first served master", 32'(resp_order[0]), 32'd3);
    check_val("second served master", 32'(resp_order[1]), 32'd2);
    check_val("third served master", 32'(resp_order[2]), 32'd0);
    master_read(0, SRAM_BASE + 16'h00a0, d[0], 1'b0);
    master_read(0, SRAM_BASE + 16'h00a2, d[2], 1'b0);
    master_read(0, SRAM_BASE + 16'h00a3, d[3], 1'b0);
  endtask

  task automatic test_mask();
    wb_dat_t d1;
    wb_dat_t d3;
    d1 = rand_bits(16);
    d3 = rand_bits(16);
    @(posedge wb_clk_i);
    wbm_mask_i[3] <= 1'b0;
    resp_order.delete();
    fork
      master_write(3, SRAM_BASE + 16'h00b3, d3, 1'b0);
      begin
        master_write(1, SRAM_BASE + 16'h00b1, d1, 1'b0);
        repeat (4) @(posedge wb_clk_i);
        check_val("responses while master 3 masked", 32'(resp_order.size()), 32'd1);
        wbm_mask_i[3] <= 1'b1;
      end
    join
    check_val("first served master", 32'(resp_order[0]), 32'd1);
    check_val("second served master", 32'(resp_order[1]), 32'd3);
    master_read(0, SRAM_BASE + 16'h00b1, d1, 1'b0);
    master_read(0, SRAM_BASE + 16'h00b3, d3, 1'b0);
  endtask

  task automatic test_unmapped();
    master_read(2, 16'h2000, '0, 1'b1);
    check_val("unmapped err latency", 32'(last_lat), 32'd3);
    master_read(2, REG_BASE + 16'd7, `WB_ARB_VERSION, 1'b0);
  endtask

  initial begin
    lfsr_q       = 32'hf7f8;
    wr_count_exp = 0;
    fail_shown   = 1'b0;
    run_done     = 1'b0;
    wb_rst_i     = 1'b1;
    wbm_cyc_i    = '0;
    wbm_stb_i    = '0;
    wbm_we_i     = '0;
    wbm_mask_i   = '1;
    wbm_adr_i    = '0;
    wbm_dat_i    = '0;
    repeat (5) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    @(posedge wb_clk_i);
    test_reset_state();
    test_reg_bank();
    test_sram();
    test_priority();
    test_mask();
    test_unmapped();
    run_done = 1'b1;
    $display("TB PASSED");
    $finish;
  end

  // Catches runs cut short by a bound assertion
  final begin
    if (!run_done && !fail_shown) begin
      $display("TB FAILED");
    end
  end

endmodule

`default_nettype wire

//--- wb_arb_sys_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arb_sys_assertions
  import wb_bus_pkg::*;
#(
  parameter int unsigned NUM_MASTERS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  wb_adr_t                adr_i,
  input  wb_dat_t                dat_w_i,
  input  logic                   ack_i,
  input  logic                   err_i,
  input  logic [NUM_MASTERS-1:0] mst_cyc_i,
  input  logic [NUM_MASTERS-1:0] mst_stb_i,
  input  wbm_id_t                id_i
);

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ack_i && err_i))
    else $error("Shared bus ack and err high together");

  a_resp_width: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i || err_i) |=> !(ack_i || err_i))
    else $error("Shared bus response wider than one cycle");

  a_resp_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i || err_i) |-> cyc_i)
    else $error("Shared bus response outside an open cycle");

  // Request held until the response
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (cyc_i && !(ack_i || err_i)) |=>
      (cyc_i && stb_i && $stable(we_i) && $stable(adr_i) && $stable(dat_w_i)))
    else $error("Shared bus request changed while the cycle was open");

  // Open cycle belongs to the granted master, which is still requesting
  a_open_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i |-> (mst_cyc_i[id_i] && mst_stb_i[id_i]))
    else $error("Shared bus cycle open for a master that is not requesting");

endmodule

bind wbm_arbiter wb_arb_sys_assertions #(
  .NUM_MASTERS (NUM_MASTERS)
) u_bus_assert (
  .clk_i     (wb_clk_i),
  .rst_i     (wb_rst_i),
  .cyc_i     (bus_o.cyc),
  .stb_i     (bus_o.stb),
  .we_i      (bus_o.we),
  .adr_i     (bus_o.adr),
  .dat_w_i   (bus_o.dat_w),
  .ack_i     (bus_o.ack),
  .err_i     (bus_o.err),
  .mst_cyc_i (wbm_cyc_i),
  .mst_stb_i (wbm_stb_i),
  .id_i      (wbm_id_o)
);

`default_nettype wire

//--- wb_arb_sys.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_settings.svh"

module wb_arb_sys
  import wb_bus_pkg::*;
(
  input  logic                                     wb_clk_i,
  input  logic                                     wb_rst_i,

  input  logic [`WB_NUM_MASTERS-1:0]               wbm_cyc_i,
  input  logic [`WB_NUM_MASTERS-1:0]               wbm_stb_i,
  input  logic [`WB_NUM_MASTERS-1:0]               wbm_we_i,
  input  logic [`WB_NUM_MASTERS*`WB_ADR_W-1:0]     wbm_adr_i,
  input  logic [`WB_NUM_MASTERS*`WB_DAT_W-1:0]     wbm_dat_i,
  output wb_dat_t                                  wbm_dat_o,
  output logic [`WB_NUM_MASTERS-1:0]               wbm_ack_o,
  output logic [`WB_NUM_MASTERS-1:0]               wbm_err_o,

  input  logic [`WB_NUM_MASTERS-1:0]               wbm_mask_i,
  output wbm_id_t                                  wbm_id_o
);

  wb_bus_if bus_shared ();
  wb_bus_if bus_sram ();
  wb_bus_if bus_regs ();

  wbm_arbiter #(
    .NUM_MASTERS (`WB_NUM_MASTERS)
  ) u_arbiter (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_we_i   (wbm_we_i),
    .wbm_mask_i (wbm_mask_i),
    .wbm_adr_i  (wbm_adr_i),
    .wbm_dat_i  (wbm_dat_i),
    .wbm_dat_o  (wbm_dat_o),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_err_o  (wbm_err_o),
    .wbm_id_o   (wbm_id_o),
    .bus_o      (bus_shared.master)
  );

  wb_addr_decoder u_decoder (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (bus_shared.slave),
    .sram_o   (bus_sram.master),
    .regs_o   (bus_regs.master)
  );

  wb_reg_bank u_reg_bank (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (bus_regs.slave)
  );

  wb_sram u_sram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (bus_sram.slave)
  );

endmodule

`default_nettype wire

//--- wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_settings.svh"

module wb_sram
  import wb_bus_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,

  wb_bus_if.slave  bus_i
);

  localparam int unsigned AW = $clog2(`WB_SRAM_WORDS);

  wb_dat_t         mem [`WB_SRAM_WORDS];
  logic [AW-1:0]   word;
  logic            wait_q;
  logic            start;

  assign word  = bus_i.adr[AW-1:0];
  assign start = bus_i.cyc && bus_i.stb && !wait_q && !bus_i.ack;

  // First cycle is the wait state, access and ack happen in the second
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wait_q    <= 1'b0;
      bus_i.ack <= 1'b0;
    end else begin
      wait_q    <= start;
      bus_i.ack <= wait_q;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wait_q) begin
      if (bus_i.we) begin
        mem[word] <= bus_i.dat_w;
      end
      bus_i.dat_r <= mem[word]; // Old contents on a write cycle
    end
  end

  assign bus_i.err = 1'b0;

endmodule

`default_nettype wire

//--- wb_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_settings.svh"

module wb_reg_bank
  import wb_bus_pkg::*;
  import wb_map_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,

  wb_bus_if.slave  bus_i
);

  localparam int unsigned NUM_SCRATCH = `WB_REG_WORDS - 2;
  localparam reg_idx_t    CNT_IDX     = reg_idx_t'(`WB_REG_WORDS - 2);
  localparam reg_idx_t    VER_IDX     = reg_idx_t'(`WB_REG_WORDS - 1);

  wb_dat_t [NUM_SCRATCH-1:0] scratch;
  wb_dat_t                   wr_count;
  wb_dat_t                   rd_data;
  reg_idx_t                  idx;
  logic                      start;
  logic                      ro_hit;

  assign idx    = reg_idx_t'(bus_i.adr); // Offset from the decoder is already in range
  assign start  = bus_i.cyc && bus_i.stb && !bus_i.ack && !bus_i.err;
  assign ro_hit = (idx >= CNT_IDX);

  always_comb begin
    case (idx)
      CNT_IDX: rd_data = wr_count;
      VER_IDX: rd_data = wb_dat_t'(`WB_ARB_VERSION);
      default: rd_data = scratch[idx];
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      scratch   <= '0;
      wr_count  <= '0;
      bus_i.ack <= 1'b0;
      bus_i.err <= 1'b0;
    end else begin
      bus_i.ack <= start && !(bus_i.we && ro_hit);
      bus_i.err <= start && bus_i.we && ro_hit; // Writes to count or version are refused
      if (start && bus_i.we && !ro_hit) begin
        scratch[idx] <= bus_i.dat_w;
        wr_count     <= wr_count + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      bus_i.dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- wb_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_arb_settings.svh"

module wb_addr_decoder
  import wb_bus_pkg::*;
  import wb_map_pkg::*;
(
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,

  wb_bus_if.slave   bus_i,
  wb_bus_if.master  sram_o,
  wb_bus_if.master  regs_o
);

  wb_region_e region;
  wb_adr_t    sram_off;
  wb_adr_t    regs_off;
  logic       unm_err;

  // Addresses below a base wrap to large offsets
  assign sram_off = bus_i.adr - wb_adr_t'(`WB_SRAM_BASE);
  assign regs_off = bus_i.adr - wb_adr_t'(`WB_REG_BASE);

  always_comb begin
    if (sram_off < wb_adr_t'(`WB_SRAM_WORDS)) begin
      region = SRAM;
    end else if (regs_off < wb_adr_t'(`WB_REG_WORDS)) begin
      region = REGS;
    end else begin
      region = UNMAPPED;
    end
  end

  assign sram_o.cyc   = bus_i.cyc && (region == SRAM);
  assign sram_o.stb   = bus_i.stb && (region == SRAM);
  assign sram_o.we    = bus_i.we;
  assign sram_o.adr   = sram_off;
  assign sram_o.dat_w = bus_i.dat_w;

  assign regs_o.cyc   = bus_i.cyc && (region == REGS);
  assign regs_o.stb   = bus_i.stb && (region == REGS);
  assign regs_o.we    = bus_i.we;
  assign regs_o.adr   = regs_off;
  assign regs_o.dat_w = bus_i.dat_w;

  // Local error response for holes in the map, one cycle wide
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      unm_err <= 1'b0;
    end else begin
      unm_err <= bus_i.cyc && bus_i.stb && (region == UNMAPPED) && !unm_err;
    end
  end

  always_comb begin
    bus_i.ack   = 1'b0;
    bus_i.err   = 1'b0;
    bus_i.dat_r = '0;
    case (region)
      SRAM: begin
        bus_i.ack   = sram_o.ack;
        bus_i.err   = sram_o.err;
        bus_i.dat_r = sram_o.dat_r;
      end
      REGS: begin
        bus_i.ack   = regs_o.ack;
        bus_i.err   = regs_o.err;
        bus_i.dat_r = regs_o.dat_r;
      end
      default: begin
        bus_i.err = unm_err;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- wbm_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbm_arbiter
  import wb_bus_pkg::*;
#(
  parameter int unsigned NUM_MASTERS = 2 ** $bits(wbm_id_t)
) (
  input  logic                         wb_clk_i,
  input  logic                         wb_rst_i,

  input  logic    [NUM_MASTERS-1:0]    wbm_cyc_i,
  input  logic    [NUM_MASTERS-1:0]    wbm_stb_i,
  input  logic    [NUM_MASTERS-1:0]    wbm_we_i,
  input  logic    [NUM_MASTERS-1:0]    wbm_mask_i,
  input  wb_adr_t [NUM_MASTERS-1:0]    wbm_adr_i,
  input  wb_dat_t [NUM_MASTERS-1:0]    wbm_dat_i,
  output wb_dat_t                      wbm_dat_o,
  output logic    [NUM_MASTERS-1:0]    wbm_ack_o,
  output logic    [NUM_MASTERS-1:0]    wbm_err_o,
  output wbm_id_t                      wbm_id_o,

  wb_bus_if.master                     bus_o
);

  logic [NUM_MASTERS-1:0] req;
  logic [NUM_MASTERS-1:0] pending;
  logic [NUM_MASTERS-1:0] done_mask;
  logic                   busy;
  wbm_id_t                active_id;
  wbm_id_t                next_id;
  wb_resp_e               resp;

  assign req = wbm_cyc_i & wbm_stb_i & wbm_mask_i; // Masked-off masters never latch

  // Last pending index wins, so the highest master has priority
  always_comb begin
    next_id = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (pending[i]) begin
        next_id = wbm_id_t'(i);
      end
    end
  end

  always_comb begin
    if (bus_o.err) begin
      resp = ERR;
    end else if (bus_o.ack) begin
      resp = ACK;
    end else begin
      resp = NONE;
    end
  end

  always_comb begin
    done_mask = '0;
    if (resp != NONE) begin
      done_mask[active_id] = 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending   <= '0;
      busy      <= 1'b0;
      active_id <= '0;
    end else begin
      // Master still holds cyc in its response cycle, so the clear must win
      pending <= (pending | req) & ~done_mask;
      if (resp != NONE) begin
        busy <= 1'b0;
      end else if (!busy && |pending) begin
        busy      <= 1'b1;
        active_id <= next_id;
      end
    end
  end

  // Shared bus follows the granted master
  assign bus_o.cyc   = busy;
  assign bus_o.stb   = busy;
  assign bus_o.we    = wbm_we_i[active_id];
  assign bus_o.adr   = wbm_adr_i[active_id];
  assign bus_o.dat_w = wbm_dat_i[active_id];

  always_comb begin
    wbm_ack_o = '0;
    wbm_err_o = '0;
    wbm_ack_o[active_id] = (resp == ACK);
    wbm_err_o[active_id] = (resp == ERR);
  end

  assign wbm_dat_o = bus_o.dat_r; // Read data is broadcast
  assign wbm_id_o  = active_id;

endmodule

`default_nettype wire

//--- wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if
  import wb_bus_pkg::*;
();

  logic    cyc;
  logic    stb;
  logic    we;
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_dat_t dat_r;
  logic    ack;
  logic    err;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

//--- wb_map_pkg.sv
`default_nettype none

`include "wb_arb_settings.svh"

package wb_map_pkg;

  // Target selected by the address decoder
  typedef enum logic [1:0] {
    SRAM,
    REGS,
    UNMAPPED
  } wb_region_e;

  typedef logic [$clog2(`WB_REG_WORDS)-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- wb_bus_pkg.sv
`default_nettype none

`include "wb_arb_settings.svh"

package wb_bus_pkg;

  typedef logic [`WB_ADR_W-1:0] wb_adr_t;
  typedef logic [`WB_DAT_W-1:0] wb_dat_t;

  typedef logic [$clog2(`WB_NUM_MASTERS)-1:0] wbm_id_t;

  // Outcome of one bus cycle
  typedef enum logic [1:0] {
    NONE,
    ACK,
    ERR
  } wb_resp_e;

endpackage

`default_nettype wire

//--- wb_arb_settings.svh
`ifndef WB_ARB_SETTINGS_SVH
`define WB_ARB_SETTINGS_SVH

// Masters sharing the bus
`define WB_NUM_MASTERS 4

`define WB_ADR_W 16
`define WB_DAT_W 16

// Word-addressed regions
`define WB_SRAM_BASE  16'h0000
`define WB_SRAM_WORDS 256
`define WB_REG_BASE   16'h1000
`define WB_REG_WORDS  8

// Read-only identification word in the register bank
`define WB_ARB_VERSION 16'h0A51

`endif
